//--- led_pkg.sv
package led_pkg;

    // panel geometry, one half of the 64x64 panel
    localparam int col_bits = 6;
    localparam int row_bits = 5;                     // row inside one 32-row half
    localparam int addr_bits = row_bits + col_bits;  // bank address is {row, col}
    localparam int num_cols = 64;

    // frame timing
    localparam int sub_bits = 8;      // pwm subframe counter
    localparam int frame_bits = 4;
    localparam int row_gap = 3;       // idle cycles after the last column of a row

    // every steal_period-th subframe belongs to the painter
    localparam int steal_period = 16;

    // cursor behaviour
    localparam logic [7:0] hue_step = 8'd4;  // hue added per forward step
    localparam int repeat_bits = 15;         // auto-repeat divider for a held forward

    // rgb565 as stored in the frame buffer
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // cursor coordinate, wraps at 64 in both directions
    // for y, bit 5 picks the bank and the low bits pick the row
    typedef logic [col_bits-1:0] coord_t;

endpackage

//--- frame_timer.sv
module frame_timer import led_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,
    output logic [col_bits-1:0] col,
    output logic [row_bits-1:0] row,
    output logic [sub_bits-1:0] subframe,
    output logic                row_start,
    output logic                steal
);

    logic [frame_bits-1:0]        frame;
    logic [$clog2(row_gap)-1:0]   gap_cnt;
    logic                         in_gap;

    // painter owns the subframe when the low bits are all ones
    assign steal = &subframe[$clog2(steal_period)-1:0];

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            col       <= '0;
            row       <= '0;
            subframe  <= '0;
            frame     <= '0;
            gap_cnt   <= '0;
            in_gap    <= 1'b0;
            row_start <= 1'b1;  // first row starts straight out of reset
        end else if (!in_gap) begin
            row_start <= 1'b0;
            if (col == num_cols - 1) begin
                in_gap  <= 1'b1;
                gap_cnt <= '0;
                // subframe steps as soon as the last column of row 31 is read
                // the scanner delays it to line up with the read data
                if (&row) begin
                    subframe <= subframe + 1'b1;
                    if (&subframe) begin
                        frame <= frame + 1'b1;  // wraps, nobody looks at the top
                    end
                end
            end else begin
                col <= col + 1'b1;
            end
        end else begin
            gap_cnt <= gap_cnt + 1'b1;
            if (gap_cnt == row_gap - 1) begin
                in_gap    <= 1'b0;
                col       <= '0;
                row       <= row + 1'b1;
                row_start <= 1'b1;
            end
        end
    end

endmodule

//--- cursor_painter.sv
module cursor_painter import led_pkg::*; (
    input  logic                 clk,
    input  logic                 pll_locked,
    input  logic                 paint_en,
    input  logic                 btn_left,
    input  logic                 btn_forward,
    input  logic                 btn_right,
    output logic [addr_bits-1:0] paint_addr,
    output logic [1:0]           paint_bank_we,
    output pixel_t               paint_pixel
);

    typedef enum logic [1:0] {
        S_START,
        S_CLEAR,
        S_INIT,
        S_MAIN
    } setup_t;

    // order matters, the draw states step through by +1
    typedef enum logic [3:0] {
        R_WAIT,
        R_CLR_MID,
        R_CLR_LEFT,
        R_CLR_TOP,
        R_CLR_RIGHT,
        R_SET_MID,
        R_SET_LEFT,
        R_SET_TOP,
        R_SET_RIGHT,
        R_AWAIT
    } redraw_t;

    setup_t                 setup_state;
    redraw_t                redraw_state;
    coord_t                 cur_x, cur_y;
    coord_t                 nxt_x, nxt_y;
    logic [1:0]             dir_x, dir_y;       // heading, each -1/0/+1
    logic [1:0]             nxt_dir_x, nxt_dir_y;
    coord_t                 dx, dy;
    coord_t                 cell_x, cell_y;
    logic [7:0]             hue;
    logic [7:0]             red8, green8, blue8;
    pixel_t                 cursor_pix;
    logic [repeat_bits-1:0] divider;

    // single hsv channel at power 1
    function automatic logic [7:0] hue_channel(input logic [7:0] h);
        if (h < 8'd43) begin
            return h;
        end else if (h < 8'd128) begin
            return 8'd43;
        end else if (h < 8'd170) begin
            return 8'd170 - h;
        end else begin
            return 8'd0;
        end
    endfunction

    assign red8   = hue_channel(hue + 8'd85);
    assign green8 = hue_channel(hue);
    assign blue8  = hue_channel(hue + 8'd170);

    always_comb begin
        cursor_pix.red   = red8[7:3];
        cursor_pix.green = green8[7:2];
        cursor_pix.blue  = blue8[7:3];
    end

    assign dx = {{(col_bits - 2){dir_x[1]}}, dir_x};
    assign dy = {{(col_bits - 2){dir_y[1]}}, dir_y};

    // which arm of the plus the current draw state touches
    always_comb begin
        case (redraw_state)
            R_CLR_LEFT, R_SET_LEFT: begin
                cell_x = cur_x + dy;
                cell_y = cur_y - dx;
            end
            R_CLR_TOP, R_SET_TOP: begin
                cell_x = cur_x + dx;
                cell_y = cur_y + dy;
            end
            R_CLR_RIGHT, R_SET_RIGHT: begin
                cell_x = cur_x - dy;
                cell_y = cur_y + dx;
            end
            default: begin
                cell_x = cur_x;
                cell_y = cur_y;
            end
        endcase
    end

    // outputs hold the pending write, it lands on the next enabled edge
    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            setup_state   <= S_START;
            redraw_state  <= R_WAIT;
            cur_x         <= 6'd32;
            cur_y         <= 6'd32;
            dir_x         <= 2'd1;  // facing +x
            dir_y         <= 2'd0;
            nxt_x         <= '0;
            nxt_y         <= '0;
            nxt_dir_x     <= '0;
            nxt_dir_y     <= '0;
            hue           <= '0;
            divider       <= '0;
            paint_addr    <= '0;
            paint_bank_we <= '0;
            paint_pixel   <= '0;
        end else if (paint_en) begin
            case (setup_state)
                S_START: begin
                    paint_addr    <= '0;
                    paint_bank_we <= 2'b11;  // blank both halves together
                    paint_pixel   <= '0;
                    setup_state   <= S_CLEAR;
                end
                S_CLEAR: begin
                    paint_addr <= paint_addr + 1'b1;
                    if (&paint_addr) begin
                        paint_bank_we <= '0;
                        setup_state   <= S_INIT;
                    end
                end
                S_INIT: begin
                    divider     <= '0;
                    setup_state <= S_MAIN;
                end
                S_MAIN: begin
                    divider <= divider + 1'b1;
                    case (redraw_state)
                        R_WAIT: begin
                            paint_bank_we <= '0;
                            if (btn_forward) begin
                                hue          <= hue + hue_step;
                                nxt_x        <= cur_x + dx;
                                nxt_y        <= cur_y + dy;
                                nxt_dir_x    <= dir_x;
                                nxt_dir_y    <= dir_y;
                                redraw_state <= R_CLR_MID;
                            end else if (btn_right) begin  // counterclockwise
                                nxt_x        <= cur_x;
                                nxt_y        <= cur_y;
                                nxt_dir_x    <= -dir_y;
                                nxt_dir_y    <= dir_x;
                                redraw_state <= R_CLR_MID;
                            end else if (btn_left) begin  // clockwise
                                nxt_x        <= cur_x;
                                nxt_y        <= cur_y;
                                nxt_dir_x    <= dir_y;
                                nxt_dir_y    <= -dir_x;
                                redraw_state <= R_CLR_MID;
                            end
                        end
                        R_CLR_MID, R_CLR_LEFT, R_CLR_TOP, R_CLR_RIGHT,
                        R_SET_MID, R_SET_LEFT, R_SET_TOP, R_SET_RIGHT: begin
                            paint_addr    <= {cell_y[row_bits-1:0], cell_x};
                            paint_bank_we <= {cell_y[col_bits-1], ~cell_y[col_bits-1]};
                            paint_pixel   <= (redraw_state >= R_SET_MID) ? cursor_pix : '0;
                            if (redraw_state == R_CLR_RIGHT) begin
                                // old plus fully erased, switch to the new pose
                                cur_x <= nxt_x;
                                cur_y <= nxt_y;
                                dir_x <= nxt_dir_x;
                                dir_y <= nxt_dir_y;
                            end
                            redraw_state <= redraw_t'(redraw_state + 4'd1);
                        end
                        default: begin  // R_AWAIT
                            paint_bank_we <= '0;
                            // a held forward repeats when the divider wraps
                            if ((!btn_forward || divider == '0) && !btn_left && !btn_right) begin
                                redraw_state <= R_WAIT;
                            end
                        end
                    endcase
                end
                default: begin
                    setup_state <= S_START;
                end
            endcase
        end
    end

endmodule

//--- frame_buffer.sv
module frame_buffer import led_pkg::*; (
    input  logic                 clk,
    input  logic                 pll_locked,
    input  logic                 steal,
    input  logic [1:0]           paint_bank_we,
    input  logic [addr_bits-1:0] paint_addr,
    input  pixel_t               paint_pixel,
    input  logic [row_bits-1:0]  row,
    input  logic [col_bits-1:0]  col,
    output logic                 paint_en,
    output pixel_t               pix0,
    output pixel_t               pix1,
    output logic                 pix_valid
);

    // bank 0 is the upper half of the panel, bank 1 the lower
    pixel_t               bank_mem [2][2**addr_bits];
    logic [addr_bits-1:0] addr;

    // painter owns the single port exactly while it is enabled
    // that window starts and ends inside row gaps, so no scanner column is lost
    assign addr = paint_en ? paint_addr : {row, col};

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            paint_en  <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            paint_en  <= steal;
            pix_valid <= !steal;  // reads during a stolen subframe show black
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (paint_en && paint_bank_we[b]) begin
                bank_mem[b][addr] <= paint_pixel;
            end
        end
        pix0 <= bank_mem[0][addr];
        pix1 <= bank_mem[1][addr];
    end

endmodule

//--- panel_scanner.sv
module panel_scanner import led_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,
    input  pixel_t              pix0,
    input  pixel_t              pix1,
    input  logic                pix_valid,
    input  logic [sub_bits-1:0] subframe,
    input  logic                row_start,
    input  logic [row_bits-1:0] row,
    output logic [2:0]          panel_rgb0,  // {blue, green, red}
    output logic [2:0]          panel_rgb1,
    output logic [row_bits-1:0] panel_row,
    output logic                panel_blank,
    output logic                panel_latch,
    output logic                panel_sclk
);

    typedef enum logic [2:0] {
        SC_IDLE,
        SC_SHIFT,
        SC_BLANK,
        SC_LATCH,
        SC_UNBLANK
    } scan_t;

    scan_t                 state;
    logic [col_bits-1:0]   col_cnt;     // column now sitting in pix
    logic                  start_d;
    logic [sub_bits-1:0]   sub_d;       // subframe of the read now in pix
    logic [row_bits-1:0]   shift_row;
    logic [sub_bits-1:0]   cmp;
    logic [2:0]            rgb0_next, rgb1_next;

    // reversed bits spread each duty cycle over the subframes
    function automatic logic [sub_bits-1:0] bit_rev(input logic [sub_bits-1:0] v);
        logic [sub_bits-1:0] r;
        for (int i = 0; i < sub_bits; i++) begin
            r[i] = v[sub_bits-1-i];
        end
        return r;
    endfunction

    function automatic logic [2:0] pwm_bits(input pixel_t p, input logic [sub_bits-1:0] c);
        logic [7:0] r8, g8, b8;
        r8 = {p.red, 3'b000};
        g8 = {p.green, 2'b00};
        b8 = {p.blue, 3'b000};
        return {b8 > c, g8 > c, r8 > c};
    endfunction

    assign cmp       = bit_rev(sub_d);
    assign rgb0_next = pix_valid ? pwm_bits(pix0, cmp) : 3'b000;
    assign rgb1_next = pix_valid ? pwm_bits(pix1, cmp) : 3'b000;

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state       <= SC_IDLE;
            col_cnt     <= '0;
            start_d     <= 1'b0;
            sub_d       <= '0;
            shift_row   <= '0;
            panel_rgb0  <= '0;
            panel_rgb1  <= '0;
            panel_row   <= '0;
            panel_blank <= 1'b1;  // dark until the first row is latched
            panel_latch <= 1'b0;
            panel_sclk  <= 1'b0;
        end else begin
            start_d <= row_start;  // lines up with column 0 in pix
            sub_d   <= subframe;
            if (row_start) begin
                shift_row <= row;
            end
            case (state)
                SC_IDLE: begin
                    if (start_d) begin
                        panel_rgb0 <= rgb0_next;
                        panel_rgb1 <= rgb1_next;
                        panel_sclk <= 1'b1;
                        col_cnt    <= 6'd1;
                        state      <= SC_SHIFT;
                    end
                end
                SC_SHIFT: begin
                    panel_rgb0 <= rgb0_next;
                    panel_rgb1 <= rgb1_next;
                    panel_sclk <= 1'b1;
                    col_cnt    <= col_cnt + 1'b1;
                    if (col_cnt == num_cols - 1) begin
                        state <= SC_BLANK;
                    end
                end
                SC_BLANK: begin
                    panel_blank <= 1'b1;
                    panel_sclk  <= 1'b0;
                    panel_rgb0  <= '0;
                    panel_rgb1  <= '0;
                    state       <= SC_LATCH;
                end
                SC_LATCH: begin
                    panel_latch <= 1'b1;  // shift register to output drivers
                    state       <= SC_UNBLANK;
                end
                default: begin  // SC_UNBLANK
                    panel_latch <= 1'b0;
                    panel_blank <= 1'b0;
                    panel_row   <= shift_row;
                    state       <= SC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- led_panel_top.sv
module led_panel_top import led_pkg::*; (
    input  logic                clk,
    input  logic                pll_locked,
    input  logic                btn_left,
    input  logic                btn_forward,
    input  logic                btn_right,
    output logic [2:0]          panel_rgb0,
    output logic [2:0]          panel_rgb1,
    output logic [row_bits-1:0] panel_row,
    output logic                panel_blank,
    output logic                panel_latch,
    output logic                panel_sclk
);

    logic [col_bits-1:0]  col;
    logic [row_bits-1:0]  row;
    logic [sub_bits-1:0]  subframe;
    logic                 row_start;
    logic                 steal;
    logic                 paint_en;
    logic [addr_bits-1:0] paint_addr;
    logic [1:0]           paint_bank_we;
    pixel_t               paint_pixel;
    pixel_t               pix0, pix1;
    logic                 pix_valid;

    frame_timer u_frame_timer (
        .clk        (clk),
        .pll_locked (pll_locked),
        .col        (col),
        .row        (row),
        .subframe   (subframe),
        .row_start  (row_start),
        .steal      (steal)
    );

    cursor_painter u_cursor_painter (
        .clk           (clk),
        .pll_locked    (pll_locked),
        .paint_en      (paint_en),
        .btn_left      (btn_left),
        .btn_forward   (btn_forward),
        .btn_right     (btn_right),
        .paint_addr    (paint_addr),
        .paint_bank_we (paint_bank_we),
        .paint_pixel   (paint_pixel)
    );

    frame_buffer u_frame_buffer (
        .clk           (clk),
        .pll_locked    (pll_locked),
        .steal         (steal),
        .paint_bank_we (paint_bank_we),
        .paint_addr    (paint_addr),
        .paint_pixel   (paint_pixel),
        .row           (row),
        .col           (col),
        .paint_en      (paint_en),
        .pix0          (pix0),
        .pix1          (pix1),
        .pix_valid     (pix_valid)
    );

    panel_scanner u_panel_scanner (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .pix0        (pix0),
        .pix1        (pix1),
        .pix_valid   (pix_valid),
        .subframe    (subframe),
        .row_start   (row_start),
        .row         (row),
        .panel_rgb0  (panel_rgb0),
        .panel_rgb1  (panel_rgb1),
        .panel_row   (panel_row),
        .panel_blank (panel_blank),
        .panel_latch (panel_latch),
        .panel_sclk  (panel_sclk)
    );

endmodule

//--- tb_led_panel.sv
module tb_led_panel;

    localparam int key_none    = 0;
    localparam int key_forward = 1;
    localparam int key_left    = 2;
    localparam int key_right   = 3;
    localparam int num_steps   = 5;

    logic       clk;
    logic       pll_locked;
    logic       btn_left;
    logic       btn_forward;
    logic       btn_right;
    logic [2:0] panel_rgb0;
    logic [2:0] panel_rgb1;
    logic [4:0] panel_row;
    logic       panel_blank;
    logic       panel_latch;
    logic       panel_sclk;

    // button, rows held, cursor pose and hue afterwards, number of lit cells
    int step_key   [num_steps] = '{key_none, key_forward, key_right, key_left, key_forward};
    int step_hold  [num_steps] = '{40, 40, 40, 40, 40};
    int step_x     [num_steps] = '{32, 33, 33, 33, 34};
    int step_y     [num_steps] = '{32, 32, 32, 32, 32};
    int step_hue   [num_steps] = '{0, 4, 4, 4, 8};
    int step_cells [num_steps] = '{0, 4, 4, 4, 4};

    // cursor model
    int model_x, model_y, model_dx, model_dy, model_hue;
    bit model_drawn;

    // panel monitor
    int         sclk_cnt, latch_cnt;
    bit         commit_pending, monitor_on;
    logic [2:0] shifted0 [64];
    logic [2:0] shifted1 [64];
    logic [2:0] lit [2][32][64];   // channels seen per cell in the window
    string      test_name;

    led_panel_top u_led_panel_top (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .btn_left    (btn_left),
        .btn_forward (btn_forward),
        .btn_right   (btn_right),
        .panel_rgb0  (panel_rgb0),
        .panel_rgb1  (panel_rgb1),
        .panel_row   (panel_row),
        .panel_blank (panel_blank),
        .panel_latch (panel_latch),
        .panel_sclk  (panel_sclk)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic int wrap64(input int v);
        return ((v % 64) + 64) % 64;
    endfunction

    // colour wheel level of one channel
    function automatic int hue_level(input int h);
        int p;
        p = h % 256;
        if (p < 43) return p;
        if (p < 128) return 43;
        if (p < 170) return 170 - p;
        return 0;
    endfunction

    // 8-bit channel value after the rgb565 round trip
    function automatic int channel_value(input int hue, input int chan);
        case (chan)
            0:       return hue_level(hue + 85) & 8'hf8;
            1:       return hue_level(hue) & 8'hfc;
            default: return hue_level(hue + 170) & 8'hf8;
        endcase
    endfunction

    function automatic int reverse8(input int v);
        int r;
        r = 0;
        for (int i = 0; i < 8; i++) begin
            r = (r << 1) | ((v >> i) & 1);
        end
        return r;
    endfunction

    function automatic bit on_cursor(input int bank, input int row, input int col);
        int y;
        y = bank * 32 + row;
        if (!model_drawn) return 0;
        return (col == model_x && y == model_y) ||
               (col == wrap64(model_x + model_dy) && y == wrap64(model_y - model_dx)) ||
               (col == wrap64(model_x + model_dx) && y == wrap64(model_y + model_dy)) ||
               (col == wrap64(model_x - model_dy) && y == wrap64(model_y + model_dx));
    endfunction

    // {b, g, r} a cell shows in one subframe
    function automatic logic [2:0] expected_rgb(input int bank, row, col, sf);
        logic [2:0] bits;
        bits = '0;
        if (on_cursor(bank, row, col) && (sf % 16) != 15) begin  // stolen subframes stay dark
            for (int ch = 0; ch < 3; ch++) begin
                bits[ch] = channel_value(model_hue, ch) > reverse8(sf);
            end
        end
        return bits;
    endfunction

    function automatic logic [2:0] expected_mask(input int bank, row, col);
        logic [2:0] bits;
        bits = '0;
        if (on_cursor(bank, row, col)) begin
            for (int ch = 0; ch < 3; ch++) begin
                bits[ch] = channel_value(model_hue, ch) != 0;
            end
        end
        return bits;
    endfunction

    // scan order and every column of one latched row against the model
    task automatic commit_row();
        int r, sf;
        r  = latch_cnt % 32;
        sf = (latch_cnt / 32) % 256;
        check_value("panel row order", r, panel_row);
        check_value("blank after latch", 0, panel_blank);
        if (monitor_on) begin
            for (int c = 0; c < 64; c++) begin
                check_value({test_name, " bank 0 pwm"}, expected_rgb(0, r, c, sf), shifted0[c]);
                check_value({test_name, " bank 1 pwm"}, expected_rgb(1, r, c, sf), shifted1[c]);
                lit[0][r][c] = lit[0][r][c] | shifted0[c];
                lit[1][r][c] = lit[1][r][c] | shifted1[c];
            end
        end
        latch_cnt++;
    endtask

    always @(negedge clk) begin
        if (!pll_locked) begin
            sclk_cnt       = 0;
            latch_cnt      = 0;
            commit_pending = 0;
        end else begin
            if (commit_pending) begin   // panel_row has moved to the latched row
                commit_pending = 0;
                commit_row();
            end
            if (panel_sclk) begin
                if (sclk_cnt < 64) begin
                    shifted0[sclk_cnt] = panel_rgb0;
                    shifted1[sclk_cnt] = panel_rgb1;
                end
                sclk_cnt++;
            end
            if (panel_latch) begin
                check_value("sclk pulses per row", 64, sclk_cnt);
                check_value("blank during latch", 1, panel_blank);
                sclk_cnt       = 0;
                commit_pending = 1;
            end
        end
    end

    task automatic wait_latches(input int target, input string what);
        int cycles;
        int limit;
        cycles = 0;
        limit  = (target - latch_cnt) * 80 + 500;
        while (latch_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout while waiting for %s, no latch pulses seen", what);
                stop_with_failure();
            end
        end
    endtask

    task automatic set_keys(input int key, input logic level);
        @(posedge clk);
        #2;
        btn_forward = level && key == key_forward;
        btn_left    = level && key == key_left;
        btn_right   = level && key == key_right;
    endtask

    task automatic move_model(input int key);
        int t;
        t = model_dx;
        case (key)
            key_forward: begin
                model_x   = wrap64(model_x + model_dx);
                model_y   = wrap64(model_y + model_dy);
                model_hue = (model_hue + 4) % 256;
            end
            key_right: begin   // counterclockwise
                model_dx = -model_dy;
                model_dy = t;
            end
            key_left: begin
                model_dx = model_dy;
                model_dy = -t;
            end
            default: ;
        endcase
        if (key != key_none) model_drawn = 1;
    endtask

    task automatic check_reset_outputs(input string name);
        check_value({name, " blank"}, 1, panel_blank);
        check_value({name, " latch"}, 0, panel_latch);
        check_value({name, " sclk"}, 0, panel_sclk);
        check_value({name, " rgb0"}, 0, panel_rgb0);
        check_value({name, " rgb1"}, 0, panel_rgb1);
    endtask

    initial begin
        int base;
        int cells;
        logic [2:0] centre;
        clk         = 1'b0;
        pll_locked  = 1'b0;
        btn_left    = 1'b0;
        btn_forward = 1'b0;
        btn_right   = 1'b0;
        monitor_on  = 0;
        model_x     = 32;
        model_y     = 32;
        model_dx    = 1;
        model_dy    = 0;
        model_hue   = 0;
        model_drawn = 0;

        @(negedge clk);
        check_reset_outputs("during reset");
        @(posedge clk);
        #2;
        pll_locked = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_reset_outputs("after reset");

        for (int s = 0; s < num_steps; s++) begin
            base      = 14 + 80 * s;   // the subframe just before a stolen one
            test_name = $sformatf("step %0d", s);
            wait_latches(32 * base, "the press point");
            set_keys(step_key[s], 1'b1);
            move_model(step_key[s]);
            wait_latches(32 * base + step_hold[s], "the end of the hold");
            set_keys(step_key[s], 1'b0);
            for (int b = 0; b < 2; b++)
                for (int r = 0; r < 32; r++)
                    for (int c = 0; c < 64; c++)
                        lit[b][r][c] = '0;
            wait_latches(32 * (base + 2), "the settle point");
            monitor_on = 1;
            wait_latches(32 * (base + 66), "the end of the monitor window");
            monitor_on = 0;

            cells = 0;
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < 32; r++) begin
                    for (int c = 0; c < 64; c++) begin
                        if (lit[b][r][c] != 0) cells++;
                    end
                end
            end
            check_value({test_name, " lit cells"}, step_cells[s], cells);
            if (step_cells[s] != 0) begin
                // cursor centre and its colour straight from the table
                centre = lit[step_y[s] / 32][step_y[s] % 32][step_x[s]];
                for (int ch = 0; ch < 3; ch++) begin
                    check_value({test_name, " centre channel"},
                                channel_value(step_hue[s], ch) != 0, centre[ch]);
                end
            end
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < 32; r++) begin
                    for (int c = 0; c < 64; c++) begin
                        check_value({test_name, " lit channels"}, expected_mask(b, r, c),
                                    lit[b][r][c]);
                    end
                end
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- files.f
led_pkg.sv
frame_timer.sv
cursor_painter.sv
frame_buffer.sv
panel_scanner.sv
led_panel_top.sv
tb_led_panel.sv

//--- Bender.yml
package:
  name: led_panel

sources:
  - led_pkg.sv
  - frame_timer.sv
  - cursor_painter.sv
  - frame_buffer.sv
  - panel_scanner.sv
  - led_panel_top.sv
  - target: test
    files:
      - tb_led_panel.sv
